// File: hw/drbg_pkg.sv
package drbg_pkg;

  // ----------------------------------------
  // Widths and basic types
  // ----------------------------------------
  localparam int WORD_W     = 64;
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;
  localparam int CNT_W      = 8;

  typedef logic [WORD_W-1:0]     word_t;      // K, V, T, entropy, nonce, tag
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;  // APB byte address
  typedef logic [APB_DATA_W-1:0] apb_data_t;
  typedef logic [CNT_W-1:0]      gen_cnt_t;   // Generate counter

  // DRBG start values
  localparam word_t K_INIT = 64'h0000_0000_0000_0000;
  localparam word_t V_INIT = 64'h0101_0101_0101_0101;

  // ----------------------------------------
  // Keyed mixer
  // ----------------------------------------
  localparam word_t MIX_KEY_IV  = 64'h6a09_e667_f3bc_c908;  // Whitens the key on a fresh absorb
  localparam word_t MIX_ROUND_C = 64'h9e37_79b9_7f4a_7c15;  // Added every round
  localparam int    MIX_ROUNDS  = 8;
  localparam int    MIX_RND_W   = $clog2(MIX_ROUNDS);

  typedef logic [MIX_RND_W-1:0] mix_rnd_t;
  localparam mix_rnd_t MIX_LAST_RND = mix_rnd_t'(MIX_ROUNDS - 1);

  // Accepted T lies in [1, DRBG_LIMIT-1]
  localparam word_t DRBG_LIMIT = 64'he000_0000_0000_0000;

  // Output FIFO
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = 2;
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;  // One extra bit to reach FIFO_DEPTH

  // ----------------------------------------
  // Register map
  // ----------------------------------------
  localparam apb_addr_t ADDR_CTRL     = 8'h00;
  localparam apb_addr_t ADDR_STATUS   = 8'h04;
  localparam apb_addr_t ADDR_ENT_LO   = 8'h08;
  localparam apb_addr_t ADDR_ENT_HI   = 8'h0C;
  localparam apb_addr_t ADDR_NONCE_LO = 8'h10;
  localparam apb_addr_t ADDR_NONCE_HI = 8'h14;
  localparam apb_addr_t ADDR_DATA_LO  = 8'h18;
  localparam apb_addr_t ADDR_DATA_HI  = 8'h1C;

  localparam int CTRL_INIT_BIT = 0;
  localparam int CTRL_NEXT_BIT = 1;
  localparam int CTRL_ZERO_BIT = 2;

  // Engine states
  typedef enum logic [3:0] {
    IDLE, INIT, NEXT,
    K_V, K_ENT, K_NONCE, V_UPD,  // K and V update
    T_GEN, CHECK,                // Candidate and range check
    K_REJ, V_REJ,                // Reject path
    WRITE
  } drbg_state_e;

endpackage

// File: hw/keyed_mix_core.sv
`timescale 1ns/10ps

module keyed_mix_core
  import drbg_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  zeroize,
  input  logic  mix_init,   // Fresh absorb
  input  logic  mix_next,   // Continue current state
  input  word_t key,
  input  word_t msg,
  output word_t tag,
  output logic  tag_valid
);

  word_t    state;      // Mixing state, also the tag
  word_t    key_q;      // Key latched at command
  mix_rnd_t round;
  logic     busy;
  word_t    round_sum;
  word_t    round_out;

  // Rotate left, amount 0 gives x back
  function automatic word_t rotl(input word_t x, input int unsigned amt);
    rotl = (x << amt) | (x >> (WORD_W - amt));
  endfunction

  // ----------------------------------------
  // One round per cycle
  // ----------------------------------------
  always_comb begin
    round_sum = state + key_q + MIX_ROUND_C;
    round_out = rotl(round_sum, 13) ^ rotl(key_q, round);  // Key rotated by round index
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= '0;
      key_q     <= '0;
      round     <= '0;
      busy      <= 1'b0;
      tag_valid <= 1'b0;
    end else if (zeroize) begin
      state     <= '0;
      key_q     <= '0;
      round     <= '0;
      busy      <= 1'b0;
      tag_valid <= 1'b0;
    end else begin
      tag_valid <= 1'b0;                      // Single cycle pulse
      if (busy) begin
        state <= round_out;
        round <= round + 1'b1;
        if (round == MIX_LAST_RND) begin
          busy      <= 1'b0;
          tag_valid <= 1'b1;                  // Tag ready after last round
        end
      end else if (mix_init) begin
        state <= key ^ MIX_KEY_IV ^ msg;      // Fresh start, absorb first word
        key_q <= key;
        round <= '0;
        busy  <= 1'b1;
      end else if (mix_next) begin
        state <= state ^ msg;                 // Chain onto previous tag
        key_q <= key;
        round <= '0;
        busy  <= 1'b1;
      end
    end
  end

  assign tag = state;  // Stable until next command

endmodule

// File: hw/drbg_engine.sv
`timescale 1ns/10ps

module drbg_engine
  import drbg_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  zeroize,
  input  logic  init_cmd,
  input  logic  next_cmd,
  input  word_t entropy,
  input  word_t nonce,
  output logic  ready,
  output logic  wr_en,
  output word_t wr_data,
  input  logic  full
);

  drbg_state_e state_q;
  drbg_state_e state_d;

  word_t    k_reg;
  word_t    v_reg;      // Also holds T after T_GEN
  gen_cnt_t cnt_reg;
  logic     is_gen;     // Generate flow, continue to T after V update
  logic     ready_q;

  // Mixer interface
  logic  mix_init;
  logic  mix_next;
  word_t mix_msg;
  word_t tag;
  logic  tag_valid;
  logic  enter;
  logic  start_fresh;
  logic  start_cont;

  keyed_mix_core mix_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .mix_init  (mix_init),
    .mix_next  (mix_next),
    .key       (k_reg),
    .msg       (mix_msg),
    .tag       (tag),
    .tag_valid (tag_valid)
  );

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (ready_q && init_cmd) state_d = INIT;       // Init wins over next
        else if (ready_q && next_cmd) state_d = NEXT;
      end
      INIT, NEXT: state_d = K_V;
      K_V:     if (tag_valid) state_d = K_ENT;
      K_ENT:   if (tag_valid) state_d = K_NONCE;
      K_NONCE: if (tag_valid) state_d = V_UPD;
      V_UPD:   if (tag_valid) state_d = is_gen ? T_GEN : IDLE;
      T_GEN:   if (tag_valid) state_d = CHECK;
      CHECK: begin
        // T out of range, reseed K and V and try again
        if ((v_reg == '0) || (v_reg >= DRBG_LIMIT)) state_d = K_REJ;
        else state_d = WRITE;
      end
      K_REJ:   if (tag_valid) state_d = V_REJ;
      V_REJ:   if (tag_valid) state_d = T_GEN;
      WRITE:   if (!full) state_d = IDLE;               // Hold on back-pressure
      default: state_d = IDLE;
    endcase
  end

  // Mixer command on entry into an absorbing state
  always_comb begin
    enter       = (state_d != state_q);
    start_fresh = enter && (state_d inside {K_V, V_UPD, T_GEN, K_REJ, V_REJ});
    start_cont  = enter && (state_d inside {K_ENT, K_NONCE});
  end

  // Message word per state
  always_comb begin
    case (state_q)
      K_V, V_UPD, T_GEN, V_REJ: mix_msg = v_reg;
      K_ENT:   mix_msg = entropy;
      K_NONCE: mix_msg = {cnt_reg, nonce[WORD_W-CNT_W-1:0]};  // Counter in top byte
      K_REJ:   mix_msg = {v_reg[WORD_W-1:8], 8'h00};
      default: mix_msg = '0;
    endcase
  end

  // ----------------------------------------
  // State and control registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q  <= IDLE;
      ready_q  <= 1'b0;
      mix_init <= 1'b0;
      mix_next <= 1'b0;
    end else if (zeroize) begin
      state_q  <= IDLE;
      ready_q  <= 1'b0;
      mix_init <= 1'b0;
      mix_next <= 1'b0;
    end else begin
      state_q  <= state_d;
      ready_q  <= (state_d == IDLE);
      mix_init <= start_fresh;
      mix_next <= start_cont;
    end
  end

  // K, V and counter updates
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      k_reg   <= '0;
      v_reg   <= '0;
      cnt_reg <= '0;
      is_gen  <= 1'b0;
    end else if (zeroize) begin
      k_reg   <= '0;
      v_reg   <= '0;
      cnt_reg <= '0;
      is_gen  <= 1'b0;
    end else begin
      case (state_q)
        INIT: begin
          k_reg   <= K_INIT;
          v_reg   <= V_INIT;
          cnt_reg <= '0;
          is_gen  <= 1'b0;
        end
        NEXT: begin
          cnt_reg <= cnt_reg + 1'b1;
          is_gen  <= 1'b1;
        end
        K_NONCE, K_REJ:      if (tag_valid) k_reg <= tag;  // New K
        V_UPD, T_GEN, V_REJ: if (tag_valid) v_reg <= tag;  // New V, or T
        default: ;
      endcase
    end
  end

  assign ready   = ready_q;
  assign wr_en   = (state_q == WRITE) && !full;  // Exactly one cycle
  assign wr_data = v_reg;

endmodule

// File: hw/rand_fifo.sv
`timescale 1ns/10ps

module rand_fifo
  import drbg_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  zeroize,
  input  logic  wr_en,
  input  word_t wr_data,
  input  logic  rd_en,
  output word_t rd_data,
  output logic  empty,
  output logic  full
);

  word_t     mem [FIFO_DEPTH];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;
  logic      do_wr;
  logic      do_rd;

  // Overflow and underflow are dropped
  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  assign full    = (count == fifo_cnt_t'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign rd_data = mem[rd_ptr];  // Head word, no pop

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
  end

  // Pointers wrap at FIFO_DEPTH
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (zeroize) begin
      wr_ptr <= '0;   // Flush
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;    // Both or neither
      endcase
    end
  end

endmodule

// File: hw/drbg_apb_regs.sv
`timescale 1ns/10ps

module drbg_apb_regs
  import drbg_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  // APB slave
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  // Engine side
  output logic      init_cmd,
  output logic      next_cmd,
  output logic      zeroize,
  output word_t     entropy,
  output word_t     nonce,
  input  logic      ready,
  // FIFO side
  input  word_t     rd_data,
  input  logic      empty,
  input  logic      full,
  output logic      rd_en
);

  logic access;
  logic wr_acc;
  logic rd_acc;
  logic ctrl_wr;
  logic mapped;

  assign access  = psel & penable;     // Access phase
  assign wr_acc  = access & pwrite;
  assign rd_acc  = access & ~pwrite;
  assign ctrl_wr = wr_acc & (paddr == ADDR_CTRL);
  assign pready  = 1'b1;               // No wait states

  // ----------------------------------------
  // Address decode and errors
  // ----------------------------------------
  always_comb begin
    case (paddr)
      ADDR_CTRL, ADDR_STATUS, ADDR_ENT_LO, ADDR_ENT_HI,
      ADDR_NONCE_LO, ADDR_NONCE_HI, ADDR_DATA_LO, ADDR_DATA_HI: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  // Unmapped access, or pop from an empty FIFO
  assign pslverr = access & (~mapped | (rd_acc & (paddr == ADDR_DATA_HI) & empty));

  // DATA_HI read pops the head
  assign rd_en = rd_acc & (paddr == ADDR_DATA_HI) & ~empty;

  // Read mux
  always_comb begin
    prdata = '0;
    if (rd_acc) begin
      case (paddr)
        ADDR_STATUS:   prdata = {{(APB_DATA_W-3){1'b0}}, full, ~empty, ready};
        ADDR_ENT_LO:   prdata = entropy[31:0];
        ADDR_ENT_HI:   prdata = entropy[63:32];
        ADDR_NONCE_LO: prdata = nonce[31:0];
        ADDR_NONCE_HI: prdata = nonce[63:32];
        ADDR_DATA_LO:  prdata = rd_data[31:0];   // Peek only
        ADDR_DATA_HI:  prdata = rd_data[63:32];
        default:       prdata = '0;              // CTRL reads as zero
      endcase
    end
  end

  // ----------------------------------------
  // Write side
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      entropy <= '0;
      nonce   <= '0;
    end else if (wr_acc) begin
      case (paddr)
        ADDR_ENT_LO:   entropy[31:0]  <= pwdata;
        ADDR_ENT_HI:   entropy[63:32] <= pwdata;
        ADDR_NONCE_LO: nonce[31:0]    <= pwdata;
        ADDR_NONCE_HI: nonce[63:32]   <= pwdata;
        default: ;
      endcase
    end
  end

  // CTRL bits become single cycle pulses
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init_cmd <= 1'b0;
      next_cmd <= 1'b0;
      zeroize  <= 1'b0;
    end else begin
      init_cmd <= ctrl_wr & pwdata[CTRL_INIT_BIT];
      next_cmd <= ctrl_wr & pwdata[CTRL_NEXT_BIT];
      zeroize  <= ctrl_wr & pwdata[CTRL_ZERO_BIT];
    end
  end

endmodule

// File: hw/drbg_top.sv
`timescale 1ns/10ps

module drbg_top
  import drbg_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  // Regs to engine
  logic  init_cmd;
  logic  next_cmd;
  logic  zeroize;    // Also flushes the FIFO
  word_t entropy;
  word_t nonce;
  logic  ready;

  // Engine and regs to FIFO
  logic  wr_en;
  word_t wr_data;
  logic  rd_en;
  word_t rd_data;
  logic  empty;
  logic  full;

  // ----------------------------------------
  // APB register block
  // ----------------------------------------
  drbg_apb_regs regs_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .init_cmd (init_cmd),
    .next_cmd (next_cmd),
    .zeroize  (zeroize),
    .entropy  (entropy),
    .nonce    (nonce),
    .ready    (ready),
    .rd_data  (rd_data),
    .empty    (empty),
    .full     (full),
    .rd_en    (rd_en)
  );

  // Producer
  drbg_engine engine_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .zeroize  (zeroize),
    .init_cmd (init_cmd),
    .next_cmd (next_cmd),
    .entropy  (entropy),
    .nonce    (nonce),
    .ready    (ready),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full)
  );

  rand_fifo fifo_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .zeroize  (zeroize),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty),
    .full     (full)
  );

endmodule

// File: verif/drbg_model.svh
`ifndef DRBG_MODEL_SVH
`define DRBG_MODEL_SVH

// ----------------------------------------
// Reference state
// ----------------------------------------
word_t       model_k;
word_t       model_v;
gen_cnt_t    model_cnt;
logic [63:0] rng_state;   // xorshift state

// Rotate left, a zero amount leaves the word as is
function automatic word_t rot_left(input word_t x, input int amt);
  if (amt == 0) begin
    return x;
  end
  return (x << amt) | (x >> (WORD_W - amt));
endfunction

// MIX_ROUNDS keyed add-rotate-xor rounds on the state
function automatic word_t mix_rounds(input word_t st, input word_t key);
  word_t s;
  int    r;
  s = st;
  for (r = 0; r < MIX_ROUNDS; r++) begin
    s = rot_left(s + key + MIX_ROUND_C, 13) ^ rot_left(key, r);  // Key turns with the round
  end
  return s;
endfunction

// New absorb, whitened key then message
function automatic word_t absorb_fresh(input word_t key, input word_t msg);
  return mix_rounds(key ^ MIX_KEY_IV ^ msg, key);
endfunction

// Chained absorb onto the last tag
function automatic word_t absorb_more(input word_t st, input word_t key, input word_t msg);
  return mix_rounds(st ^ msg, key);
endfunction

// K from V, entropy and counter-tagged nonce, then V under the new K
function automatic void update_kv(input word_t ent, input word_t non);
  word_t s;
  s       = absorb_fresh(model_k, model_v);
  s       = absorb_more(s, model_k, ent);
  s       = absorb_more(s, model_k, {model_cnt, non[WORD_W-CNT_W-1:0]});
  model_k = s;
  model_v = absorb_fresh(model_k, model_v);
endfunction

function automatic void model_instantiate(input word_t ent, input word_t non);
  model_k   = K_INIT;
  model_v   = V_INIT;
  model_cnt = '0;
  update_kv(ent, non);
endfunction

// One accepted output word, reject loop included
function automatic word_t model_generate(input word_t ent, input word_t non);
  int tries;
  tries     = 0;
  model_cnt = model_cnt + 1'b1;
  update_kv(ent, non);
  model_v = absorb_fresh(model_k, model_v);      // T, also the new V
  while (((model_v == '0) || (model_v >= DRBG_LIMIT)) && (tries < 64)) begin
    model_k = absorb_fresh(model_k, {model_v[WORD_W-1:8], 8'h00});
    model_v = absorb_fresh(model_k, model_v);
    model_v = absorb_fresh(model_k, model_v);    // Fresh T
    tries++;
  end
  return model_v;
endfunction

// 64-bit xorshift step
function automatic logic [63:0] next_random();
  logic [63:0] y;
  y         = rng_state;
  y         = y ^ (y << 13);
  y         = y ^ (y >> 7);
  y         = y ^ (y << 17);
  rng_state = y;
  return y;
endfunction

`endif

// File: verif/drbg_tb.sv
`timescale 1ns/10ps

module drbg_tb
  import drbg_pkg::*;
();

  localparam int CLK_HALF_NS   = 4;
  localparam int RESET_CYCLES  = 10;
  localparam int POLL_LIMIT    = 300;  // STATUS reads before giving up
  localparam int STALL_READS   = 30;   // Longer than one clean generate
  localparam int NUM_OPS       = 16;   // Instantiates and generates, all scenarios
  localparam int WORST_ABSORBS = 20;   // Five per generate plus reject loops
  localparam int WATCHDOG_NS   =
    NUM_OPS * (MIX_ROUNDS + 1) * WORST_ABSORBS * 4 * 2 * CLK_HALF_NS;

  logic      clk;
  logic      reset_n;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  logic      bus_err;      // pslverr of the last access phase
  word_t     ent_word;
  word_t     nonce_word;
  word_t     expect_q[$];  // Words stuck in the FIFO, oldest first
  apb_data_t status;
  apb_data_t rdata;
  word_t     got_word;
  word_t     exp_word;
  int        i;

  `include "drbg_model.svh"

  drbg_top drbg_top_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #CLK_HALF_NS clk = ~clk;  // 8 ns period

  // ----------------------------------------
  // Reporting
  // ----------------------------------------
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // ----------------------------------------
  // APB driver
  // ----------------------------------------
  task automatic bus_cycle(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                           output apb_data_t data);
    @(posedge clk);                 // Setup phase
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;                // Access phase
    @(negedge clk);                 // Sample mid access once outputs settle
    data    = prdata;
    bus_err = pslverr;
    check_value("pready", pready, 1'b1);
    @(posedge clk);                 // Transfer completes on this edge
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t ignored;
    bus_cycle(1'b1, addr, data, ignored);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    bus_cycle(1'b0, addr, '0, data);
  endtask

  task automatic read_status();
    apb_read(ADDR_STATUS, status);
  endtask

  // Poll one STATUS bit until it is set
  task automatic poll_status(input int bit_idx, input string what);
    int n;
    n = 0;
    read_status();
    while (!status[bit_idx]) begin
      n++;
      if (n > POLL_LIMIT) fail_run(what);
      read_status();
    end
  endtask

  // Peek the low half and pop with the high half
  task automatic read_word(output word_t w);
    apb_data_t lo;
    apb_data_t hi;
    apb_read(ADDR_DATA_LO, lo);
    check_value("pslverr", bus_err, 1'b0);
    apb_read(ADDR_DATA_HI, hi);
    check_value("pslverr", bus_err, 1'b0);
    w = {hi, lo};
  endtask

  task automatic load_inputs();
    ent_word   = next_random();
    nonce_word = next_random();
    apb_write(ADDR_ENT_LO, ent_word[31:0]);
    apb_write(ADDR_ENT_HI, ent_word[63:32]);
    apb_write(ADDR_NONCE_LO, nonce_word[31:0]);
    apb_write(ADDR_NONCE_HI, nonce_word[63:32]);
  endtask

  task automatic instantiate_drbg();
    load_inputs();
    apb_write(ADDR_CTRL, 32'h1);
    model_instantiate(ent_word, nonce_word);
    poll_status(0, "Engine never became ready after instantiate");
  endtask

  task automatic generate_and_check();
    word_t w;
    apb_write(ADDR_CTRL, 32'h2);
    exp_word = model_generate(ent_word, nonce_word);
    poll_status(1, "FIFO stayed empty after a generate command");
    read_word(w);
    check_value("rand_word", w, exp_word);
  endtask

  // ----------------------------------------
  // Scenarios
  // ----------------------------------------
  initial begin
    clk         = 1'b0;
    reset_n     = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    bus_err     = 1'b0;
    rng_state   = 64'd4545;   // Fixed seed
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;

    // Idle after reset with errors for an empty pop and holes in the map
    read_status();
    check_value("status", status, 32'h1);
    apb_read(ADDR_DATA_HI, rdata);
    check_value("pslverr", bus_err, 1'b1);
    apb_read(8'h20, rdata);
    check_value("pslverr", bus_err, 1'b1);
    apb_write(8'h24, 32'hdead_beef);
    check_value("pslverr", bus_err, 1'b1);

    // Instantiate writes nothing
    instantiate_drbg();
    apb_read(ADDR_ENT_HI, rdata);
    check_value("ent_hi", rdata, ent_word[63:32]);
    read_status();
    check_value("status_not_empty", status[1], 1'b0);

    for (i = 0; i < 3; i++) generate_and_check();

    // ----------------------------------------
    // Back-pressure with a full FIFO
    // ----------------------------------------
    for (i = 0; i < FIFO_DEPTH; i++) begin
      apb_write(ADDR_CTRL, 32'h2);
      expect_q.push_back(model_generate(ent_word, nonce_word));
      poll_status(0, "Engine never became ready while filling the FIFO");
    end
    read_status();
    check_value("status_full", status[2], 1'b1);
    apb_write(ADDR_CTRL, 32'h2);                       // Fifth word stalls in WRITE
    expect_q.push_back(model_generate(ent_word, nonce_word));
    repeat (STALL_READS) begin
      read_status();
      check_value("status_ready", status[0], 1'b0);
      check_value("status_full", status[2], 1'b1);
    end
    repeat (FIFO_DEPTH + 1) begin
      poll_status(1, "FIFO ran dry while draining the stalled words");
      read_word(got_word);
      check_value("rand_word", got_word, expect_q.pop_front());
    end
    poll_status(0, "Engine never became ready after the drain");
    read_status();
    check_value("status_not_empty", status[1], 1'b0);

    // Second command while busy is dropped
    apb_write(ADDR_CTRL, 32'h2);
    apb_write(ADDR_CTRL, 32'h2);
    exp_word = model_generate(ent_word, nonce_word);
    poll_status(1, "FIFO stayed empty after a generate command");
    read_word(got_word);
    check_value("rand_word", got_word, exp_word);
    poll_status(0, "Engine never became ready after the busy command");
    read_status();
    check_value("status_not_empty", status[1], 1'b0);
    generate_and_check();                              // Counter advanced once only

    // ----------------------------------------
    // Zeroize and restart
    // ----------------------------------------
    for (i = 0; i < 2; i++) begin
      apb_write(ADDR_CTRL, 32'h2);
      void'(model_generate(ent_word, nonce_word));     // Words left in the FIFO
      poll_status(0, "Engine never became ready before zeroize");
    end
    read_status();
    check_value("status_not_empty", status[1], 1'b1);
    apb_write(ADDR_CTRL, 32'h4);
    poll_status(0, "Engine never became ready after zeroize");
    read_status();
    check_value("status", status, 32'h1);              // Flushed
    apb_read(ADDR_DATA_HI, rdata);
    check_value("pslverr", bus_err, 1'b1);
    instantiate_drbg();                                // Fresh random inputs
    for (i = 0; i < 2; i++) generate_and_check();

    $display("No errors");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    fail_run("Watchdog timeout, the tests did not finish in time");
  end

endmodule

// File: list.f
+incdir+verif
hw/drbg_pkg.sv
hw/keyed_mix_core.sv
hw/drbg_engine.sv
hw/rand_fifo.sv
hw/drbg_apb_regs.sv
hw/drbg_top.sv
verif/drbg_tb.sv
